//--- design/vrf_pkg.sv
// Element, strobe and operand-queue types of the vector lane
// Elements are fixed at 32 bits with one strobe bit per byte
// The default geometry needs NrRegs * ElemPerReg to be a multiple of NrBanks
package vrf_pkg;

  // One vector element
  typedef logic [31:0] elen_t;

  // Byte enables of one element
  typedef logic [$bits(elen_t)/8-1:0] strb_t;

  // Queues fed by the register file crossbar
  typedef enum logic [1:0] {
    ALU_A,
    ALU_B,
    READBACK
  } opqueue_e;

  localparam int unsigned NrOperandQueues = 3;

  // Default lane geometry
  localparam int unsigned NrBanksDef    = 4;
  localparam int unsigned NrRegsDef     = 8;
  localparam int unsigned ElemPerRegDef = 8;

endpackage : vrf_pkg

//--- design/lane_cmd_pkg.sv
// Host-visible map of the lane and the command word layout
// Addresses are byte addresses and bits 1..0 are ignored
// Register and element fields assume 8 registers of 8 elements
package lane_cmd_pkg;

  localparam int unsigned WbAdrWidth = 12;

  // Elementwise operation codes
  typedef enum logic [1:0] {
    VADD,
    VSUB,
    VXOR
  } vop_e;

  // Address map
  localparam logic [WbAdrWidth-1:0] VRF_BASE    = 12'h000;
  localparam logic [WbAdrWidth-1:0] VRF_MASK    = 12'h0FF;
  localparam logic [WbAdrWidth-1:0] CMD_ADDR    = 12'h100;
  localparam logic [WbAdrWidth-1:0] STATUS_ADDR = 12'h104;

  // Command word fields, LSB positions
  localparam int unsigned CMD_VD_LSB  = 0;
  localparam int unsigned CMD_VS1_LSB = 4;
  localparam int unsigned CMD_VS2_LSB = 8;
  localparam int unsigned CMD_OP_LSB  = 12;

  // Element location inside the VRF window
  localparam int unsigned ADR_REG_LSB  = 5;
  localparam int unsigned ADR_ELEM_LSB = 2;

endpackage : lane_cmd_pkg

//--- design/vrf_access_if.sv
// One element-granular access from a requester to the bank arbiter
// All fields stay stable from req until the cycle in which gnt is high
// That cycle completes the transfer
`timescale 1ns/1ps

interface vrf_access_if #(
  parameter int unsigned NrRegs     = vrf_pkg::NrRegsDef,
  parameter int unsigned ElemPerReg = vrf_pkg::ElemPerRegDef
);
  import vrf_pkg::*;

  localparam int unsigned RegW  = $clog2(NrRegs);
  localparam int unsigned ElemW = $clog2(ElemPerReg);

  logic             req;
  logic             gnt;
  logic [RegW-1:0]  reg_idx;
  logic [ElemW-1:0] elem_idx;
  logic             wen;
  elen_t            wdata;
  strb_t            be;
  // Queue that receives read data
  opqueue_e         tgt;

  modport initiator (output req, reg_idx, elem_idx, wen, wdata, be, tgt, input gnt);
  modport arbiter (input req, reg_idx, elem_idx, wen, wdata, be, tgt, output gnt);

endinterface : vrf_access_if

//--- design/vrf_bank_if.sv
// Per-bank request vectors between the arbiter and the register file
// No handshake, a request is taken in the cycle it is presented
// At most one request per bank and cycle
`timescale 1ns/1ps

interface vrf_bank_if #(
  parameter int unsigned NrBanks   = vrf_pkg::NrBanksDef,
  parameter int unsigned AddrWidth = 4
);
  import vrf_pkg::*;

  logic     [NrBanks-1:0]                req;
  // Word address inside the bank
  logic     [NrBanks-1:0][AddrWidth-1:0] addr;
  logic     [NrBanks-1:0]                wen;
  elen_t    [NrBanks-1:0]                wdata;
  strb_t    [NrBanks-1:0]                be;
  opqueue_e [NrBanks-1:0]                tgt;

  modport ctrl (output req, addr, wen, wdata, be, tgt);
  modport bank (input req, addr, wen, wdata, be, tgt);

endinterface : vrf_bank_if

//--- design/lane_decode.sv
// Wishbone classic slave of the lane
// Each cycle gets exactly one registered ack
// VRF reads take at least 3 cycles, status reads 1 cycle
// A command write while busy is held without ack until busy falls
// Unmapped addresses are acked and read as zero
`timescale 1ns/1ps

module lane_decode #(
  parameter int unsigned  NrRegs     = vrf_pkg::NrRegsDef,
  parameter int unsigned  ElemPerReg = vrf_pkg::ElemPerRegDef,
  localparam int unsigned RegW       = $clog2(NrRegs)
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  // Wishbone slave
  input  logic                               cyc_i,
  input  logic                               stb_i,
  input  logic                               we_i,
  input  logic [lane_cmd_pkg::WbAdrWidth-1:0] adr_i,
  input  vrf_pkg::elen_t                     dat_i,
  input  vrf_pkg::strb_t                     sel_i,
  output vrf_pkg::elen_t                     dat_o,
  output logic                               ack_o,
  // Host element access
  vrf_access_if.initiator                    host_acc,
  input  vrf_pkg::elen_t                     readback_i,
  input  logic                               readback_valid_i,
  // Command to the sequencer
  output logic                               cmd_valid_o,
  output logic [RegW-1:0]                    cmd_vd_o,
  output logic [RegW-1:0]                    cmd_vs1_o,
  output logic [RegW-1:0]                    cmd_vs2_o,
  output lane_cmd_pkg::vop_e                 cmd_op_o,
  input  logic                               busy_i
);
  import vrf_pkg::*;
  import lane_cmd_pkg::*;

  localparam int unsigned ElemW = $clog2(ElemPerReg);

  typedef enum logic [1:0] {
    S_IDLE,
    S_ACCESS,
    S_READ,
    S_CMD
  } state_e;

  state_e state_q;
  logic   ack_q;
  elen_t  dat_q;
  logic   strobe;
  logic   is_vrf;

  // New strobe, the ack cycle itself is skipped
  assign strobe = cyc_i && stb_i && !ack_q;
  assign is_vrf = (adr_i & ~VRF_MASK) == VRF_BASE;

  // Fields follow the Wishbone inputs, held by the master until ack
  assign host_acc.req      = (state_q == S_ACCESS);
  assign host_acc.reg_idx  = adr_i[ADR_REG_LSB +: RegW];
  assign host_acc.elem_idx = adr_i[ADR_ELEM_LSB +: ElemW];
  assign host_acc.wen      = we_i;
  assign host_acc.wdata    = dat_i;
  assign host_acc.be       = sel_i;
  assign host_acc.tgt      = READBACK;

  assign ack_o = ack_q;
  assign dat_o = dat_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= S_IDLE;
      ack_q       <= 1'b0;
      dat_q       <= '0;
      cmd_valid_o <= 1'b0;
      cmd_vd_o    <= '0;
      cmd_vs1_o   <= '0;
      cmd_vs2_o   <= '0;
      cmd_op_o    <= VADD;
    end else begin
      ack_q       <= 1'b0;
      cmd_valid_o <= 1'b0;
      unique case (state_q)
        S_IDLE: begin
          if (strobe) begin
            if (is_vrf) begin
              state_q <= S_ACCESS;
            end else if (we_i && adr_i == CMD_ADDR) begin
              state_q <= S_CMD;
            end else begin
              // Status and unmapped answer next cycle
              ack_q <= 1'b1;
              dat_q <= (adr_i == STATUS_ADDR) ? elen_t'(busy_i) : '0;
            end
          end
        end
        S_ACCESS: begin
          if (host_acc.gnt) begin
            if (we_i) begin
              ack_q   <= 1'b1;
              state_q <= S_IDLE;
            end else begin
              state_q <= S_READ;
            end
          end
        end
        S_READ: begin
          // Only the host targets the readback queue
          if (readback_valid_i) begin
            dat_q   <= readback_i;
            ack_q   <= 1'b1;
            state_q <= S_IDLE;
          end
        end
        S_CMD: begin
          if (!busy_i) begin
            cmd_valid_o <= 1'b1;
            cmd_vd_o    <= dat_i[CMD_VD_LSB +: RegW];
            cmd_vs1_o   <= dat_i[CMD_VS1_LSB +: RegW];
            cmd_vs2_o   <= dat_i[CMD_VS2_LSB +: RegW];
            cmd_op_o    <= vop_e'(dat_i[CMD_OP_LSB +: $bits(vop_e)]);
            ack_q       <= 1'b1;
            state_q     <= S_IDLE;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

endmodule : lane_decode

//--- design/lane_execute.sv
// Command sequencer, operand fetch and per-bank arbitration
// Element e of register v lives in bank (v + e) mod NrBanks
// at word (v * ElemPerReg + e) div NrBanks
// Bank priority is write-back, then operand fetch, then host
// Fetches stop while FifoDepth elements are outstanding
// Source registers must stay stable while busy
`timescale 1ns/1ps

module lane_execute #(
  parameter int unsigned  NrBanks    = vrf_pkg::NrBanksDef,
  parameter int unsigned  NrRegs     = vrf_pkg::NrRegsDef,
  parameter int unsigned  ElemPerReg = vrf_pkg::ElemPerRegDef,
  parameter int unsigned  FifoDepth  = 4,
  localparam int unsigned RegW       = $clog2(NrRegs)
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            cmd_valid_i,
  input  logic [RegW-1:0] cmd_vs1_i,
  input  logic [RegW-1:0] cmd_vs2_i,
  output logic            busy_o,
  input  logic            fifo_pop_i,
  input  logic            wb_done_i,
  vrf_access_if.arbiter   host_acc,
  vrf_access_if.arbiter   wb_acc,
  vrf_bank_if.ctrl        bank
);
  import vrf_pkg::*;

  localparam int unsigned ElemW = $clog2(ElemPerReg);
  localparam int unsigned BankW = $clog2(NrBanks);
  localparam int unsigned AddrW = $clog2(NrRegs * ElemPerReg / NrBanks);
  localparam int unsigned CredW = $clog2(FifoDepth + 1);

  typedef logic [BankW-1:0] bank_t;
  typedef logic [AddrW-1:0] addr_t;

  // Barber-pole layout
  function automatic bank_t bank_of(input logic [RegW-1:0] v, input logic [ElemW-1:0] e);
    int unsigned sum;
    sum = v + e;
    return bank_t'(sum % NrBanks);
  endfunction

  function automatic addr_t addr_of(input logic [RegW-1:0] v, input logic [ElemW-1:0] e);
    int unsigned lin;
    lin = v * ElemPerReg + e;
    return addr_t'(lin / NrBanks);
  endfunction

  logic             busy_q;
  logic             active_q;
  // High while the vs2 half of a same-bank element is pending
  logic             phase_q;
  logic [ElemW-1:0] elem_q;
  logic [ElemW-1:0] wb_cnt_q;
  logic [CredW-1:0] credits_q;
  bank_t            bank_a, bank_b, bank_wb, bank_host;
  logic             split, credit_ok, want_a, want_b, blocked, issue_a, issue_b;

  assign bank_a    = bank_of(cmd_vs1_i, elem_q);
  assign bank_b    = bank_of(cmd_vs2_i, elem_q);
  assign bank_wb   = bank_of(wb_acc.reg_idx, wb_acc.elem_idx);
  assign bank_host = bank_of(host_acc.reg_idx, host_acc.elem_idx);

  // Same bank means two fetch cycles
  assign split     = (bank_a == bank_b);
  assign credit_ok = credits_q < CredW'(FifoDepth);
  assign want_a    = active_q && !phase_q && credit_ok;
  assign want_b    = active_q && (phase_q || (!split && credit_ok));
  // A fetch cycle stalls as a whole when write-back holds one of its banks
  assign blocked   = wb_acc.req && ((want_a && bank_wb == bank_a) ||
                                    (want_b && bank_wb == bank_b));
  assign issue_a   = want_a && !blocked;
  assign issue_b   = want_b && !blocked;

  // Write-back has top priority and is never refused
  assign wb_acc.gnt   = wb_acc.req;
  assign host_acc.gnt = host_acc.req &&
                        !(wb_acc.req && bank_wb == bank_host) &&
                        !(issue_a && bank_a == bank_host) &&
                        !(issue_b && bank_b == bank_host);
  assign busy_o = busy_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q    <= 1'b0;
      active_q  <= 1'b0;
      phase_q   <= 1'b0;
      elem_q    <= '0;
      wb_cnt_q  <= '0;
      credits_q <= '0;
    end else begin
      // One credit per element, returned on FIFO pop
      credits_q <= credits_q + CredW'(issue_a) - CredW'(fifo_pop_i);
      if (cmd_valid_i && !busy_q) begin
        busy_q   <= 1'b1;
        active_q <= 1'b1;
        phase_q  <= 1'b0;
        elem_q   <= '0;
        wb_cnt_q <= '0;
      end else begin
        if (issue_a && split) begin
          phase_q <= 1'b1;
        end else if (issue_b) begin
          phase_q <= 1'b0;
          elem_q  <= elem_q + 1'b1;
          if (elem_q == ElemW'(ElemPerReg - 1)) active_q <= 1'b0;
        end
        // Busy ends with the last write-back
        if (wb_done_i) begin
          wb_cnt_q <= wb_cnt_q + 1'b1;
          if (wb_cnt_q == ElemW'(ElemPerReg - 1)) busy_q <= 1'b0;
        end
      end
    end
  end

  // Per-bank request steering
  always_comb begin
    for (int unsigned b = 0; b < NrBanks; b++) begin
      bank.req[b]   = 1'b0;
      bank.wen[b]   = 1'b0;
      bank.addr[b]  = '0;
      bank.wdata[b] = '0;
      bank.be[b]    = '0;
      bank.tgt[b]   = ALU_A;
      if (wb_acc.req && bank_wb == bank_t'(b)) begin
        bank.req[b]   = 1'b1;
        bank.wen[b]   = wb_acc.wen;
        bank.addr[b]  = addr_of(wb_acc.reg_idx, wb_acc.elem_idx);
        bank.wdata[b] = wb_acc.wdata;
        bank.be[b]    = wb_acc.be;
        bank.tgt[b]   = wb_acc.tgt;
      end else if (issue_a && bank_a == bank_t'(b)) begin
        bank.req[b]  = 1'b1;
        bank.addr[b] = addr_of(cmd_vs1_i, elem_q);
        bank.tgt[b]  = ALU_A;
      end else if (issue_b && bank_b == bank_t'(b)) begin
        bank.req[b]  = 1'b1;
        bank.addr[b] = addr_of(cmd_vs2_i, elem_q);
        bank.tgt[b]  = ALU_B;
      end else if (host_acc.gnt && bank_host == bank_t'(b)) begin
        bank.req[b]   = 1'b1;
        bank.wen[b]   = host_acc.wen;
        bank.addr[b]  = addr_of(host_acc.reg_idx, host_acc.elem_idx);
        bank.wdata[b] = host_acc.wdata;
        bank.be[b]    = host_acc.be;
        bank.tgt[b]   = host_acc.tgt;
      end
    end
  end

endmodule : lane_execute

//--- design/vector_regfile.sv
// Banked vector register file of one lane
// Each bank is single ported with byte-enabled writes
// Read data and its valid appear one cycle after the request
// At most one bank may target a given queue per cycle
`timescale 1ns/1ps

module vector_regfile #(
  parameter int unsigned NrBanks    = vrf_pkg::NrBanksDef,
  parameter int unsigned NrRegs     = vrf_pkg::NrRegsDef,
  parameter int unsigned ElemPerReg = vrf_pkg::ElemPerRegDef
) (
  input  logic                                           clk_i,
  input  logic                                           rst_ni,
  vrf_bank_if.bank                                       bank,
  output vrf_pkg::elen_t [vrf_pkg::NrOperandQueues-1:0] operand_o,
  output logic           [vrf_pkg::NrOperandQueues-1:0] operand_valid_o
);
  import vrf_pkg::*;

  localparam int unsigned NumWords = NrRegs * ElemPerReg / NrBanks;
  localparam int unsigned StrbW    = $bits(strb_t);

  elen_t                  rdata [NrBanks];
  logic     [NrBanks-1:0] rdata_valid_q;
  opqueue_e [NrBanks-1:0] tgt_q;

  // Delay read valid and target along with the bank read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_valid_q <= '0;
      tgt_q         <= {NrBanks{ALU_A}};
    end else begin
      rdata_valid_q <= bank.req & ~bank.wen;
      tgt_q         <= bank.tgt;
    end
  end

  for (genvar b = 0; b < NrBanks; b++) begin : gen_banks
    elen_t mem_q [NumWords];
    elen_t rdata_q;

    always_ff @(posedge clk_i) begin
      if (bank.req[b]) begin
        if (bank.wen[b]) begin
          for (int unsigned i = 0; i < StrbW; i++) begin
            if (bank.be[b][i]) mem_q[bank.addr[b]][8*i +: 8] <= bank.wdata[b][8*i +: 8];
          end
        end else begin
          rdata_q <= mem_q[bank.addr[b]];
        end
      end
    end

    assign rdata[b] = rdata_q;
  end : gen_banks

  // Crossbar, each queue takes the bank whose delayed target names it
  always_comb begin
    operand_o       = '0;
    operand_valid_o = '0;
    for (int unsigned q = 0; q < NrOperandQueues; q++) begin
      for (int unsigned b = 0; b < NrBanks; b++) begin
        if (rdata_valid_q[b] && tgt_q[b] == opqueue_e'(q)) begin
          operand_o[q]       = rdata[b];
          operand_valid_o[q] = 1'b1;
        end
      end
    end
  end

endmodule : vector_regfile

//--- design/lane_result.sv
// Operand pairing, ALU and element write-back
// FIFO depth must be a power of two
// Overflow is prevented by the fetch credits, not checked here
// The op and vd inputs stay stable for the whole command
`timescale 1ns/1ps

module lane_result #(
  parameter int unsigned  NrRegs     = vrf_pkg::NrRegsDef,
  parameter int unsigned  ElemPerReg = vrf_pkg::ElemPerRegDef,
  parameter int unsigned  FifoDepth  = 4,
  localparam int unsigned RegW       = $clog2(NrRegs)
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  vrf_pkg::elen_t     alu_a_i,
  input  logic               alu_a_valid_i,
  input  vrf_pkg::elen_t     alu_b_i,
  input  logic               alu_b_valid_i,
  input  lane_cmd_pkg::vop_e op_i,
  input  logic [RegW-1:0]    vd_i,
  output logic               fifo_pop_o,
  output logic               wb_done_o,
  vrf_access_if.initiator    wb_acc
);
  import vrf_pkg::*;
  import lane_cmd_pkg::*;

  localparam int unsigned PtrW  = $clog2(FifoDepth);
  localparam int unsigned ElemW = $clog2(ElemPerReg);

  elen_t            push_data [2];
  logic  [1:0]      push;
  elen_t            head [2];
  logic  [1:0]      head_valid;
  logic             pop;
  logic             res_valid_q;
  elen_t            res_q;
  logic [ElemW-1:0] wb_elem_q;

  // Slot 0 holds vs1 operands, slot 1 vs2
  assign push_data[0] = alu_a_i;
  assign push_data[1] = alu_b_i;
  assign push         = {alu_b_valid_i, alu_a_valid_i};

  for (genvar f = 0; f < 2; f++) begin : gen_fifo
    elen_t           mem_q [FifoDepth];
    logic [PtrW-1:0] wptr_q, rptr_q;
    logic [PtrW:0]   cnt_q;

    always_ff @(posedge clk_i) begin
      if (push[f]) mem_q[wptr_q] <= push_data[f];
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        wptr_q <= '0;
        rptr_q <= '0;
        cnt_q  <= '0;
      end else begin
        if (push[f]) wptr_q <= wptr_q + 1'b1;
        if (pop) rptr_q <= rptr_q + 1'b1;
        cnt_q <= cnt_q + (PtrW+1)'(push[f]) - (PtrW+1)'(pop);
      end
    end

    assign head[f]       = mem_q[rptr_q];
    assign head_valid[f] = (cnt_q != '0);
  end : gen_fifo

  // Pop a pair once the result register is free
  assign pop        = &head_valid && (!res_valid_q || wb_acc.gnt);
  assign fifo_pop_o = pop;
  assign wb_done_o  = res_valid_q && wb_acc.gnt;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      res_valid_q <= 1'b0;
      wb_elem_q   <= '0;
    end else begin
      if (pop) res_valid_q <= 1'b1;
      else if (wb_acc.gnt) res_valid_q <= 1'b0;
      // Wraps back to element 0 after the last write
      if (wb_done_o) begin
        wb_elem_q <= (wb_elem_q == ElemW'(ElemPerReg - 1)) ? '0 : wb_elem_q + 1'b1;
      end
    end
  end

  // ALU, results wrap modulo 2^32
  always_ff @(posedge clk_i) begin
    if (pop) begin
      unique case (op_i)
        VADD:    res_q <= head[0] + head[1];
        VSUB:    res_q <= head[0] - head[1];
        VXOR:    res_q <= head[0] ^ head[1];
        default: res_q <= '0;
      endcase
    end
  end

  // Whole-element write of vd
  assign wb_acc.req      = res_valid_q;
  assign wb_acc.reg_idx  = vd_i;
  assign wb_acc.elem_idx = wb_elem_q;
  assign wb_acc.wen      = 1'b1;
  assign wb_acc.wdata    = res_q;
  assign wb_acc.be       = '1;
  assign wb_acc.tgt      = ALU_A;

endmodule : lane_result

//--- design/lane_top.sv
// One vector lane behind a Wishbone classic slave port
// NrRegs * ElemPerReg must be a multiple of NrBanks
// The address map fixes 8 registers of 8 elements
// busy_o mirrors the status register
`timescale 1ns/1ps

module lane_top #(
  parameter int unsigned NrBanks    = vrf_pkg::NrBanksDef,
  parameter int unsigned NrRegs     = vrf_pkg::NrRegsDef,
  parameter int unsigned ElemPerReg = vrf_pkg::ElemPerRegDef,
  parameter int unsigned FifoDepth  = 4
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               cyc_i,
  input  logic                               stb_i,
  input  logic                               we_i,
  input  logic [lane_cmd_pkg::WbAdrWidth-1:0] adr_i,
  input  logic [31:0]                        dat_i,
  input  logic [3:0]                         sel_i,
  output logic [31:0]                        dat_o,
  output logic                               ack_o,
  output logic                               busy_o
);
  import vrf_pkg::*;
  import lane_cmd_pkg::*;

  localparam int unsigned RegW  = $clog2(NrRegs);
  localparam int unsigned AddrW = $clog2(NrRegs * ElemPerReg / NrBanks);

  vrf_access_if #(.NrRegs(NrRegs), .ElemPerReg(ElemPerReg)) host_acc ();
  vrf_access_if #(.NrRegs(NrRegs), .ElemPerReg(ElemPerReg)) wb_acc ();
  vrf_bank_if #(.NrBanks(NrBanks), .AddrWidth(AddrW)) bank ();

  elen_t [NrOperandQueues-1:0] operand;
  logic  [NrOperandQueues-1:0] operand_valid;
  logic                        cmd_valid;
  logic  [RegW-1:0]            cmd_vd, cmd_vs1, cmd_vs2;
  vop_e                        cmd_op;
  logic                        busy, fifo_pop, wb_done;

  assign busy_o = busy;

  lane_decode #(.NrRegs(NrRegs), .ElemPerReg(ElemPerReg)) u_decode (
    .clk_i, .rst_ni, .cyc_i, .stb_i, .we_i, .adr_i, .dat_i, .sel_i, .dat_o, .ack_o,
    .host_acc         (host_acc),
    .readback_i       (operand[READBACK]),
    .readback_valid_i (operand_valid[READBACK]),
    .cmd_valid_o      (cmd_valid),
    .cmd_vd_o         (cmd_vd),
    .cmd_vs1_o        (cmd_vs1),
    .cmd_vs2_o        (cmd_vs2),
    .cmd_op_o         (cmd_op),
    .busy_i           (busy)
  );

  lane_execute #(
    .NrBanks(NrBanks), .NrRegs(NrRegs), .ElemPerReg(ElemPerReg), .FifoDepth(FifoDepth)
  ) u_execute (
    .clk_i, .rst_ni,
    .cmd_valid_i (cmd_valid),
    .cmd_vs1_i   (cmd_vs1),
    .cmd_vs2_i   (cmd_vs2),
    .busy_o      (busy),
    .fifo_pop_i  (fifo_pop),
    .wb_done_i   (wb_done),
    .host_acc    (host_acc),
    .wb_acc      (wb_acc),
    .bank        (bank)
  );

  vector_regfile #(.NrBanks(NrBanks), .NrRegs(NrRegs), .ElemPerReg(ElemPerReg)) u_vrf (
    .clk_i, .rst_ni,
    .bank            (bank),
    .operand_o       (operand),
    .operand_valid_o (operand_valid)
  );

  lane_result #(.NrRegs(NrRegs), .ElemPerReg(ElemPerReg), .FifoDepth(FifoDepth)) u_result (
    .clk_i, .rst_ni,
    .alu_a_i       (operand[ALU_A]),
    .alu_a_valid_i (operand_valid[ALU_A]),
    .alu_b_i       (operand[ALU_B]),
    .alu_b_valid_i (operand_valid[ALU_B]),
    .op_i          (cmd_op),
    .vd_i          (cmd_vd),
    .fifo_pop_o    (fifo_pop),
    .wb_done_o     (wb_done),
    .wb_acc        (wb_acc)
  );

endmodule : lane_top

//--- tb/lane_asserts.sv
// Concurrent checks on the Wishbone slave port of the lane
// Bound to every lane_top instance
// Read data is checked for unknown bits only on a read ack
`timescale 1ns/1ps

module lane_asserts (
  input logic        clk_i,
  input logic        rst_ni,
  input logic        cyc_i,
  input logic        stb_i,
  input logic        we_i,
  input logic        ack_o,
  input logic [31:0] dat_o
);
  int unsigned failures = 0;

  // An ack only answers an open cycle
  ack_in_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ack_o |-> (cyc_i && stb_i))
    else begin
      failures = failures + 1;
      $error("ack_o high without cyc_i and stb_i");
    end

  // Nothing is acknowledged while reset is held
  ack_in_reset: assert property (@(posedge clk_i) !rst_ni |-> !ack_o)
    else begin
      failures = failures + 1;
      $error("ack_o high during reset");
    end

  // Read data fully known when acked
  read_data_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (ack_o && !we_i) |-> !$isunknown(dat_o))
    else begin
      failures = failures + 1;
      $error("dat_o has unknown bits on a read ack");
    end

endmodule : lane_asserts

bind lane_top lane_asserts u_lane_asserts (
  .clk_i  (clk_i),
  .rst_ni (rst_ni),
  .cyc_i  (cyc_i),
  .stb_i  (stb_i),
  .we_i   (we_i),
  .ack_o  (ack_o),
  .dat_o  (dat_o)
);

//--- tb/tb_lane.sv
// Testbench of the vector lane
// Runs from the project root and reads tb/lane_patterns.txt
// Pattern lines are W addr data sel, R addr expected, C word and P
// Every ack wait and every busy poll gives up after 200 cycles
`timescale 1ns/1ps

module tb_lane;
  import lane_cmd_pkg::*;

  localparam int unsigned Timeout = 200;

  logic                  clk_i;
  logic                  rst_ni;
  logic                  cyc_i;
  logic                  stb_i;
  logic                  we_i;
  logic [WbAdrWidth-1:0] adr_i;
  logic [31:0]           dat_i;
  logic [3:0]            sel_i;
  logic [31:0]           dat_o;
  logic                  ack_o;
  logic                  busy_o;

  int unsigned errors;
  int unsigned checks;
  int unsigned timeouts;

  lane_top UUT (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .cyc_i  (cyc_i),
    .stb_i  (stb_i),
    .we_i   (we_i),
    .adr_i  (adr_i),
    .dat_i  (dat_i),
    .sel_i  (sel_i),
    .dat_o  (dat_o),
    .ack_o  (ack_o),
    .busy_o (busy_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // One Wishbone classic cycle, entered and left on a falling edge
  task automatic bus_cycle(input logic we, input logic [WbAdrWidth-1:0] adr,
                           input logic [31:0] wdata, input logic [3:0] sel,
                           output logic [31:0] rdata);
    int unsigned n;
    n     = 0;
    rdata = '0;
    cyc_i = 1'b1;
    stb_i = 1'b1;
    we_i  = we;
    adr_i = adr;
    dat_i = wdata;
    sel_i = sel;
    do begin
      @(negedge clk_i);
      n++;
    end while (!ack_o && n < Timeout);
    if (ack_o) begin
      rdata = dat_o;
      // Strobe stays up over the edge that takes the ack
      @(negedge clk_i);
    end else begin
      $display("Timeout: no ack for address %h after %0d cycles", adr, Timeout);
      timeouts++;
    end
    cyc_i = 1'b0;
    stb_i = 1'b0;
    we_i  = 1'b0;
  endtask

  // Busy is already up when a command cycle ends
  task automatic wait_idle();
    int unsigned n;
    n = 0;
    while (busy_o && n < Timeout) begin
      @(negedge clk_i);
      n++;
    end
    if (busy_o) begin
      $display("Timeout: busy still high after %0d cycles", Timeout);
      timeouts++;
    end
  endtask

  task automatic check_read(input logic [WbAdrWidth-1:0] adr, input logic [31:0] expected);
    logic [31:0] got;
    bus_cycle(1'b0, adr, '0, 4'hF, got);
    checks++;
    if (timeouts == 0 && got !== expected) begin
      errors++;
      $display("Error at %0t: read of %h returned %h, expected %h", $time, adr, got,
               expected);
    end
  endtask

  initial begin
    int               fd;
    int               code;
    logic [7:0]       kind;
    logic [31:0]      f_adr;
    logic [31:0]      f_data;
    logic [31:0]      f_sel;
    logic [31:0]      unused;
    logic [8*128-1:0] rest;
    errors   = 0;
    checks   = 0;
    timeouts = 0;
    rst_ni   = 1'b0;
    cyc_i    = 1'b0;
    stb_i    = 1'b0;
    we_i     = 1'b0;
    adr_i    = '0;
    dat_i    = '0;
    sel_i    = '0;
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);

    fd = $fopen("tb/lane_patterns.txt", "r");
    if (fd == 0) begin
      $display("Cannot open tb/lane_patterns.txt");
      errors++;
    end else begin
      // First character of each line names the action
      while (timeouts == 0 && $fscanf(fd, " %c", kind) == 1) begin
        case (kind)
          "#": code = $fgets(rest, fd);
          "W": begin
            code = $fscanf(fd, "%h %h %h", f_adr, f_data, f_sel);
            if (code != 3) begin
              $display("Malformed write line in pattern file");
              errors++;
            end
            bus_cycle(1'b1, f_adr[WbAdrWidth-1:0], f_data, f_sel[3:0], unused);
          end
          "R": begin
            code = $fscanf(fd, "%h %h", f_adr, f_data);
            if (code != 2) begin
              $display("Malformed read line in pattern file");
              errors++;
            end
            check_read(f_adr[WbAdrWidth-1:0], f_data);
          end
          "C": begin
            code = $fscanf(fd, "%h", f_data);
            // Held without ack while an earlier command runs
            bus_cycle(1'b1, CMD_ADDR, f_data, 4'hF, unused);
            // Busy is up one cycle after the command is taken
            if (timeouts == 0 && busy_o !== 1'b1) begin
              errors++;
              $display("Error at %0t: busy_o low after command %h", $time, f_data);
            end
            // Status shows busy while the elements are still running
            check_read(STATUS_ADDR, 32'h0000_0001);
          end
          "P": wait_idle();
          default: begin
            $display("Unknown action %c in pattern file", kind);
            errors++;
          end
        endcase
      end
      $fclose(fd);
    end

    if (checks == 0) begin
      $display("No read checks were run");
      errors++;
    end
    $display("Read checks: %0d, errors: %0d, timeouts: %0d, assertion failures: %0d",
             checks, errors, timeouts, UUT.u_lane_asserts.failures);
    if (errors == 0 && timeouts == 0 && UUT.u_lane_asserts.failures == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule : tb_lane

//--- tb/lane_patterns.txt
# W addr data sel | R addr expected | C command word | P wait until not busy
# Hex byte addresses, register in bits 7..5, element in bits 4..2
W 020 F0000001 F
W 024 12345678 F
W 028 80000000 F
W 02C FFFFFFFF F
W 030 00000010 F
W 034 0000ABCD F
W 038 7FFFFFFF F
W 03C 00000003 F
W 040 10000002 F
W 044 11111111 F
W 048 80000000 F
W 04C 00000001 F
W 050 00000020 F
W 054 00001234 F
W 058 00000001 F
W 05C 00000005 F
R 020 F0000001
R 028 80000000
R 034 0000ABCD
R 03C 00000003
R 044 11111111
R 04C 00000001
R 058 00000001
W 000 CAFEF00D F
R 000 CAFEF00D
W 06C 00C0FFEE F
W 098 DEADBEEF F
W 0C4 01234567 F
R 06C 00C0FFEE
R 098 DEADBEEF
R 0C4 01234567
# Byte-enable merge on v7 element 2
W 0E8 AABBCCDD F
W 0E8 11223344 5
R 0E8 AA22CC44
W 0E8 55667788 A
R 0E8 55227744
# v5 = v1 + v2, then v4 = v5 - v1 issued while busy, same-bank sources
C 00000215
C 00001154
P
R 104 00000000
R 0A0 00000003
R 0A4 23456789
R 0A8 00000000
R 0AC 00000000
R 0B0 00000030
R 0B4 0000BE01
R 0B8 80000000
R 0BC 00000008
R 080 10000002
R 084 11111111
R 088 80000000
R 094 00001234
R 09C 00000005
# v2 = v2 ^ v1 with vd equal to vs1
C 00002122
P
R 104 00000000
R 040 E0000003
R 044 03254769
R 048 00000000
R 04C FFFFFFFE
R 050 00000030
R 054 0000B9F9
R 058 7FFFFFFE
R 05C 00000006
R 020 F0000001

//--- verilog.f
design/vrf_pkg.sv
design/lane_cmd_pkg.sv
design/vrf_access_if.sv
design/vrf_bank_if.sv
design/lane_decode.sv
design/lane_execute.sv
design/vector_regfile.sv
design/lane_result.sv
design/lane_top.sv
tb/lane_asserts.sv
tb/tb_lane.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the lane testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_lane -Mdir obj_dir -f verilog.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_lane +verilator+error+limit+100)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "test passed"; then
  exit 0
fi
exit 1
